// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tbSrcDatapath -f tb.f

./obj_dir/VtbSrcDatapath | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: tb.f
verilog/srcPkg.sv
verilog/selectEncode.sv
verilog/registerFile.sv
verilog/executeUnit.sv
verilog/controlSequencer.sv
verilog/srcDatapath.sv
verif/tbSrcDatapath.sv

// File: verif/tbSrcDatapath.sv
`timescale 1ns/10ps

module tbSrcDatapath;

    localparam int NUM_INSTR  = 300;
    localparam int DONE_LIMIT = 10;  // cycles to wait for done before giving up
    localparam int CLK_HALF   = 20;

    logic            clk;
    logic            arstN;
    logic            start;
    srcPkg::word_t   instr;
    logic            busy;
    logic            done;
    srcPkg::regIdx_t rdSel;
    srcPkg::word_t   rdData;

    srcPkg::word_t   model [16];
    logic [31:0]     lfsrState;

    srcDatapath i_dut (
        .clk    (clk),
        .arstN  (arstN),
        .start  (start),
        .instr  (instr),
        .busy   (busy),
        .done   (done),
        .rdSel  (rdSel),
        .rdData (rdData)
    );

    always #CLK_HALF clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1, shifts in one new bit per call
    function automatic logic lfsrStep();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsrStep()};
        end
        return value;
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic writesResult(input srcPkg::opcode_t op);
        return op >= srcPkg::OP_ADD && op <= srcPkg::OP_ORI;
    endfunction

    // result of one instruction on the current model contents
    function automatic srcPkg::word_t expectedResult(input srcPkg::opcode_t op,
                                                     input srcPkg::regIdx_t rb,
                                                     input srcPkg::regIdx_t rc,
                                                     input logic [18:0] konst);
        srcPkg::word_t ext;
        srcPkg::word_t base;
        srcPkg::word_t result;
        ext    = {{13{konst[18]}}, konst};
        base   = (rb == 4'd0) ? 32'h0 : model[rb];  // immediates see R0 as zero
        result = '0;
        case (op)
            srcPkg::OP_ADD:  result = model[rb] + model[rc];
            srcPkg::OP_SUB:  result = model[rb] - model[rc];
            srcPkg::OP_AND:  result = model[rb] & model[rc];
            srcPkg::OP_OR:   result = model[rb] | model[rc];
            srcPkg::OP_ADDI: result = base + ext;
            srcPkg::OP_ANDI: result = base & ext;
            srcPkg::OP_ORI:  result = base | ext;
            default:         result = '0;
        endcase
        return result;
    endfunction

    function automatic srcPkg::word_t makeInstr();
        srcPkg::opcode_t op;
        srcPkg::regIdx_t ra;
        srcPkg::regIdx_t rb;
        logic [18:0]     lowBits;
        case (randomBits(3))
            32'd0:   op = srcPkg::OP_ADD;
            32'd1:   op = srcPkg::OP_SUB;
            32'd2:   op = srcPkg::OP_AND;
            32'd3:   op = srcPkg::OP_OR;
            32'd4:   op = srcPkg::OP_ADDI;
            32'd5:   op = srcPkg::OP_ANDI;
            32'd6:   op = srcPkg::OP_ORI;
            default: begin
                op = srcPkg::opcode_t'(randomBits(5));
                if (writesResult(op)) begin
                    op = op + 5'd7;  // moves it out of the executed range
                end
            end
        endcase
        ra      = srcPkg::regIdx_t'(randomBits(4));
        rb      = srcPkg::regIdx_t'(randomBits(4));
        lowBits = 19'(randomBits(19));
        if (randomBits(2) == 32'd0) begin
            rb = ra;
        end
        if (randomBits(2) == 32'd0) begin
            lowBits[18:15] = ra;  // rc equal to ra now and then
        end
        return {op, ra, rb, lowBits};
    endfunction

    task automatic checkRegisters();
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            rdSel = srcPkg::regIdx_t'(i);
            #5;
            assert (rdData === model[i])
                else failRun($sformatf("ERR rdData R%0d got %h expected %h",
                                       i, rdData, model[i]));
        end
    endtask

    // issues one instruction, optionally with a second start pulse while busy
    task automatic runInstruction(input srcPkg::word_t word, input logic injectStart);
        int   cycles;
        logic seenDone;
        cycles   = 0;
        seenDone = 1'b0;
        @(negedge clk);
        start = 1'b1;
        instr = word;
        while (!seenDone) begin
            @(negedge clk);
            cycles++;
            start = 1'b0;
            if (injectStart && cycles == 1) begin
                start = 1'b1;
                instr = randomBits(32);
            end
            assert (busy === 1'b1)
                else failRun($sformatf("ERR busy got %h expected %h in cycle %0d",
                                       busy, 1'b1, cycles));
            if (done === 1'b1) begin
                seenDone = 1'b1;
                assert (cycles == 3)
                    else failRun($sformatf("ERR done latency got %h expected %h",
                                           cycles, 3));
            end else if (cycles >= DONE_LIMIT) begin
                failRun("timeout while waiting for done after start");
            end
        end
        @(negedge clk);
        assert (busy === 1'b0 && done === 1'b0)
            else failRun($sformatf("ERR busy/done after T3 got %h/%h expected 0/0",
                                   busy, done));
    endtask

    initial begin
        srcPkg::word_t   word;
        srcPkg::word_t   result;
        srcPkg::opcode_t op;
        srcPkg::regIdx_t ra;
        clk       = 1'b0;
        arstN     = 1'b0;
        start     = 1'b0;
        instr     = '0;
        rdSel     = '0;
        lfsrState = 32'd73657;
        for (int i = 0; i < 16; i++) begin
            model[i] = '0;
        end
        repeat (16) @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);
        assert (busy === 1'b0)
            else failRun($sformatf("ERR busy after reset got %h expected %h", busy, 1'b0));
        assert (done === 1'b0)
            else failRun($sformatf("ERR done after reset got %h expected %h", done, 1'b0));
        checkRegisters();

        for (int n = 0; n < NUM_INSTR; n++) begin
            word   = makeInstr();
            op     = word[31:27];
            ra     = word[26:23];
            result = expectedResult(op, word[22:19], word[18:15], word[18:0]);
            runInstruction(word, randomBits(2) == 32'd0);
            if (writesResult(op)) begin
                model[ra] = result;
            end
            checkRegisters();
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: verilog/controlSequencer.sv
`timescale 1ns/10ps

module controlSequencer (
    input  logic           clk,
    input  logic           arstN,
    input  logic           start,
    input  srcPkg::word_t  instr,
    output srcPkg::word_t  ir,
    output logic           busy,
    output logic           done,
    output logic           gra,
    output logic           grb,
    output logic           grc,
    output logic           rin,
    output logic           rout,
    output logic           baOut,
    output logic           cOut,
    output logic           zOut,
    output logic           yIn,
    output logic           zIn,
    output srcPkg::aluOp_t aluOp
);

    typedef enum logic [1:0] {
        IDLE,
        T1,
        T2,
        T3
    } stepState_t;

    stepState_t      state;
    srcPkg::opcode_t opcode;
    logic            isImm;
    logic            isValid;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= IDLE;
            ir    <= '0;
            done  <= 1'b0;
        end else begin
            done <= (state == T2);  // high exactly during T3
            case (state)
                IDLE: begin
                    if (start) begin
                        ir    <= instr;
                        state <= T1;
                    end
                end
                T1:      state <= T2;
                T2:      state <= T3;
                default: state <= IDLE;
            endcase
        end
    end

    assign busy   = (state != IDLE);
    assign opcode = ir[31:27];

    // immediates take rb through baOut and the constant instead of rc
    always_comb begin
        isImm   = 1'b0;
        isValid = 1'b1;
        aluOp   = srcPkg::ALU_ADD;
        case (opcode)
            srcPkg::OP_ADD:  aluOp = srcPkg::ALU_ADD;
            srcPkg::OP_SUB:  aluOp = srcPkg::ALU_SUB;
            srcPkg::OP_AND:  aluOp = srcPkg::ALU_AND;
            srcPkg::OP_OR:   aluOp = srcPkg::ALU_OR;
            srcPkg::OP_ADDI: begin
                isImm = 1'b1;
                aluOp = srcPkg::ALU_ADD;
            end
            srcPkg::OP_ANDI: begin
                isImm = 1'b1;
                aluOp = srcPkg::ALU_AND;
            end
            srcPkg::OP_ORI: begin
                isImm = 1'b1;
                aluOp = srcPkg::ALU_OR;
            end
            default: isValid = 1'b0;  // the steps still run but nothing is written
        endcase
    end

    always_comb begin
        gra   = 1'b0;
        grb   = 1'b0;
        grc   = 1'b0;
        rin   = 1'b0;
        rout  = 1'b0;
        baOut = 1'b0;
        cOut  = 1'b0;
        zOut  = 1'b0;
        yIn   = 1'b0;
        zIn   = 1'b0;
        case (state)
            T1: begin
                grb   = 1'b1;
                yIn   = 1'b1;
                baOut = isImm;
                rout  = !isImm;
            end
            T2: begin
                zIn  = 1'b1;
                cOut = isImm;
                grc  = !isImm;
                rout = !isImm;
            end
            T3: begin
                gra  = 1'b1;
                zOut = 1'b1;
                rin  = isValid;
            end
            default: ;
        endcase
    end

    assert property (@(posedge clk) disable iff (!arstN) done |-> state == T3)
        else $error("controlSequencer: done outside T3");

endmodule

// File: verilog/executeUnit.sv
`timescale 1ns/10ps

module executeUnit (
    input  logic           clk,
    input  logic           arstN,
    input  srcPkg::word_t  regBus,
    input  srcPkg::word_t  cSignExtended,
    input  logic           cOut,
    input  logic           zOut,
    input  logic           yIn,
    input  logic           zIn,
    input  srcPkg::aluOp_t aluOp,
    output srcPkg::word_t  writeData
);

    srcPkg::word_t busValue;
    srcPkg::word_t yReg;
    srcPkg::word_t zReg;
    srcPkg::word_t aluResult;

    // one source per step, the register file is idle while C or Z drives
    always_comb begin
        if (cOut) begin
            busValue = cSignExtended;
        end else if (zOut) begin
            busValue = zReg;
        end else begin
            busValue = regBus;
        end
    end

    always_comb begin
        case (aluOp)
            srcPkg::ALU_ADD: aluResult = yReg + busValue;
            srcPkg::ALU_SUB: aluResult = yReg - busValue;
            srcPkg::ALU_AND: aluResult = yReg & busValue;
            default:         aluResult = yReg | busValue;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            yReg <= '0;
        end else if (yIn) begin
            yReg <= busValue;  // first operand latched in T1
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            zReg <= '0;
        end else if (zIn) begin
            zReg <= aluResult;
        end
    end

    assign writeData = busValue;

    assert property (@(posedge clk) disable iff (!arstN) !(cOut && zOut))
        else $error("executeUnit: C and Z drive the bus together");

    // no register may drive while the constant or Z owns the bus
    assert property (@(posedge clk) disable iff (!arstN) (cOut || zOut) |-> regBus == '0)
        else $error("executeUnit: register file drives during C or Z step");

endmodule

// File: verilog/registerFile.sv
`timescale 1ns/10ps

module registerFile (
    input  logic             clk,
    input  logic             arstN,
    input  srcPkg::regMask_t regInMask,
    input  srcPkg::regMask_t regOutMask,
    input  logic             baOut,
    input  srcPkg::word_t    writeData,
    output srcPkg::word_t    regBus,
    input  srcPkg::regIdx_t  rdSel,
    output srcPkg::word_t    rdData
);

    srcPkg::word_t regs [srcPkg::NUM_REGS];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < srcPkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < srcPkg::NUM_REGS; i++) begin
                if (regInMask[i]) begin
                    regs[i] <= writeData;
                end
            end
        end
    end

    // wired-or of the driving registers, nothing selected leaves the bus at zero
    always_comb begin
        regBus = '0;
        for (int i = 0; i < srcPkg::NUM_REGS; i++) begin
            if (regOutMask[i] && !(i == 0 && baOut)) begin  // R0 reads as zero base under baOut
                regBus = regBus | regs[i];
            end
        end
    end

    assign rdData = regs[rdSel];  // debug port only

    // masks come from the field decode and must never select two registers
    assert property (@(posedge clk) disable iff (!arstN) $onehot0(regInMask))
        else $error("registerFile: load mask not one-hot");

    assert property (@(posedge clk) disable iff (!arstN) $onehot0(regOutMask))
        else $error("registerFile: drive mask not one-hot");

endmodule

// File: verilog/selectEncode.sv
`timescale 1ns/10ps

module selectEncode (
    input  srcPkg::word_t    ir,
    input  logic             gra,
    input  logic             grb,
    input  logic             grc,
    input  logic             rin,
    input  logic             rout,
    input  logic             baOut,
    output srcPkg::regMask_t regInMask,
    output srcPkg::regMask_t regOutMask,
    output srcPkg::word_t    cSignExtended
);

    srcPkg::regIdx_t  fieldA;
    srcPkg::regIdx_t  fieldB;
    srcPkg::regIdx_t  fieldC;
    srcPkg::regIdx_t  selIdx;
    srcPkg::regMask_t decoded;
    logic             anySel;

    assign fieldA = ir[26:23];
    assign fieldB = ir[22:19];
    assign fieldC = ir[18:15];

    assign anySel = gra | grb | grc;

    // grc wins over grb, grb over gra
    always_comb begin
        selIdx = fieldA;
        if (grc) begin
            selIdx = fieldC;
        end else if (grb) begin
            selIdx = fieldB;
        end
    end

    // 4-to-16 one-hot, empty when no field is selected
    always_comb begin
        decoded = '0;
        for (int i = 0; i < srcPkg::NUM_REGS; i++) begin
            decoded[i] = anySel && (selIdx == srcPkg::regIdx_t'(i));
        end
    end

    assign regInMask  = rin ? decoded : '0;
    assign regOutMask = (rout | baOut) ? decoded : '0;  // baOut drives the base register too

    assign cSignExtended = {{(32 - srcPkg::CONST_WIDTH){ir[srcPkg::CONST_WIDTH - 1]}},
                            ir[srcPkg::CONST_WIDTH - 1:0]};

    // the sequencer selects one register field per step at most
    always_comb begin
        assert final ($onehot0({gra, grb, grc}))
            else $error("selectEncode: more than one register field selected");
    end

endmodule

// File: verilog/srcDatapath.sv
`timescale 1ns/10ps

module srcDatapath (
    input  logic            clk,
    input  logic            arstN,
    input  logic            start,
    input  srcPkg::word_t   instr,
    output logic            busy,
    output logic            done,
    input  srcPkg::regIdx_t rdSel,
    output srcPkg::word_t   rdData
);

    srcPkg::word_t    ir;
    srcPkg::word_t    cSignExtended;
    srcPkg::word_t    regBus;
    srcPkg::word_t    writeData;
    srcPkg::regMask_t regInMask;
    srcPkg::regMask_t regOutMask;
    srcPkg::aluOp_t   aluOp;
    logic             gra;
    logic             grb;
    logic             grc;
    logic             rin;
    logic             rout;
    logic             baOut;
    logic             cOut;
    logic             zOut;
    logic             yIn;
    logic             zIn;

    controlSequencer uSequencer (
        .clk   (clk),
        .arstN (arstN),
        .start (start),
        .instr (instr),
        .ir    (ir),
        .busy  (busy),
        .done  (done),
        .gra   (gra),
        .grb   (grb),
        .grc   (grc),
        .rin   (rin),
        .rout  (rout),
        .baOut (baOut),
        .cOut  (cOut),
        .zOut  (zOut),
        .yIn   (yIn),
        .zIn   (zIn),
        .aluOp (aluOp)
    );

    selectEncode uSelect (
        .ir            (ir),
        .gra           (gra),
        .grb           (grb),
        .grc           (grc),
        .rin           (rin),
        .rout          (rout),
        .baOut         (baOut),
        .regInMask     (regInMask),
        .regOutMask    (regOutMask),
        .cSignExtended (cSignExtended)
    );

    registerFile uRegs (
        .clk        (clk),
        .arstN      (arstN),
        .regInMask  (regInMask),
        .regOutMask (regOutMask),
        .baOut      (baOut),
        .writeData  (writeData),
        .regBus     (regBus),
        .rdSel      (rdSel),
        .rdData     (rdData)
    );

    executeUnit uExec (
        .clk           (clk),
        .arstN         (arstN),
        .regBus        (regBus),
        .cSignExtended (cSignExtended),
        .cOut          (cOut),
        .zOut          (zOut),
        .yIn           (yIn),
        .zIn           (zIn),
        .aluOp         (aluOp),
        .writeData     (writeData)
    );

endmodule

// File: verilog/srcPkg.sv
package srcPkg;

    // data and register widths of the teaching processor
    typedef logic [31:0] word_t;
    typedef logic [3:0]  regIdx_t;
    typedef logic [15:0] regMask_t;
    typedef logic [4:0]  opcode_t;
    typedef logic [1:0]  aluOp_t;

    localparam int NUM_REGS = 16;

    // width of the constant field, bits 18 to 0 of the instruction
    localparam int CONST_WIDTH = 19;

    // opcode numbering follows the source processor, the rest are not executed
    localparam opcode_t OP_ADD  = 5'd3;
    localparam opcode_t OP_SUB  = 5'd4;
    localparam opcode_t OP_AND  = 5'd5;
    localparam opcode_t OP_OR   = 5'd6;
    localparam opcode_t OP_ADDI = 5'd7;
    localparam opcode_t OP_ANDI = 5'd8;
    localparam opcode_t OP_ORI  = 5'd9;

    localparam aluOp_t ALU_ADD = 2'd0;
    localparam aluOp_t ALU_SUB = 2'd1;  // Y minus bus
    localparam aluOp_t ALU_AND = 2'd2;
    localparam aluOp_t ALU_OR  = 2'd3;

endpackage
